//--- design/dense_conv_engine.sv
// Layer 2 hidden features times W2
`timescale 1ns/1ns
`include "gat_settings.svh"

module dense_conv_engine
  import gat_mem_pkg::*;
(
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                start_i,
  input  logic [`GAT_FEAT_OUT*`GAT_FEAT_HID*`GAT_DATA_W-1:0]  w2_i,
  output logic                                                rd_req_o,
  output logic [`GAT_ADDR_W-1:0]                              rd_addr_o,
  input  logic                                                rd_gnt_i,
  input  mem_word_u                                           rd_data_i,
  output logic                                                wr_req_o,
  output logic [`GAT_ADDR_W-1:0]                              wr_addr_o,
  output logic [`GAT_WORD_W-1:0]                              wr_data_o,
  input  logic                                                wr_gnt_i,
  output logic                                                done_o
);

  localparam int ACC_W = 2 * `GAT_DATA_W + 2;
  localparam logic [1:0] S_IDLE    = 2'd0;
  localparam logic [1:0] S_RD_REQ  = 2'd1;
  localparam logic [1:0] S_RD_DATA = 2'd2;
  localparam logic [1:0] S_WRITE   = 2'd3;

  logic [1:0]                          state_q;
  logic [$clog2(`GAT_NUM_NODES)-1:0]   node_q;
  logic [1:0]                          j_q;
  logic [1:0]                          k_q;
  logic                                node_end;
  logic signed [ACC_W-1:0]             acc_q [`GAT_FEAT_OUT];
  logic signed [2*`GAT_DATA_W-1:0]     prod [`GAT_FEAT_OUT];

  assign rd_req_o  = (state_q == S_RD_REQ);
  assign rd_addr_o = `GAT_ADDR_W'(`GAT_HID_BASE + node_q * `GAT_FEAT_HID + j_q);
  assign wr_req_o  = (state_q == S_WRITE);
  assign wr_addr_o = `GAT_ADDR_W'(`GAT_OUT_BASE + node_q * `GAT_FEAT_OUT + k_q);
  assign wr_data_o = `GAT_WORD_W'(acc_q[k_q]);
  assign node_end  = wr_req_o && wr_gnt_i && (k_q == 2'(`GAT_FEAT_OUT - 1));

  // Hidden values are already clamped to the data range
  always_comb begin
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      prod[k] = $signed(rd_data_i.dense[`GAT_DATA_W-1:0]) * $signed(
        w2_i[(k * `GAT_FEAT_HID + int'(j_q)) * `GAT_DATA_W +: `GAT_DATA_W]);
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      if (start_i || node_end) begin
        acc_q[k] <= '0;
      end else if (state_q == S_RD_DATA) begin
        acc_q[k] <= acc_q[k] + ACC_W'(prod[k]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      node_q  <= '0;
      j_q     <= '0;
      k_q     <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            state_q <= S_RD_REQ;
            node_q  <= '0;
            j_q     <= '0;
            k_q     <= '0;
          end
        end
        S_RD_REQ: begin
          if (rd_gnt_i) begin
            state_q <= S_RD_DATA;
          end
        end
        S_RD_DATA: begin
          j_q     <= j_q + 1'b1;
          state_q <= (j_q == 2'(`GAT_FEAT_HID - 1)) ? S_WRITE : S_RD_REQ;
        end
        default: begin
          if (node_end) begin
            k_q    <= '0;
            node_q <= node_q + 1'b1;
            if (node_q == $clog2(`GAT_NUM_NODES)'(`GAT_NUM_NODES - 1)) begin
              state_q <= S_IDLE;
              done_o  <= 1'b1;
            end else begin
              state_q <= S_RD_REQ;
            end
          end else if (wr_gnt_i) begin
            k_q <= k_q + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

//--- design/gat_mem_arbiter.sv
// Shared feature RAM and access arbiter
`timescale 1ns/1ns
`include "gat_settings.svh"

module gat_mem_arbiter
  import gat_mem_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   host_we_i,
  input  logic [`GAT_ADDR_W-1:0] host_addr_i,
  input  logic [`GAT_WORD_W-1:0] host_din_i,
  input  logic [4:0]             host_rd_idx_i,
  input  logic                   l1_rd_req_i,
  input  logic [`GAT_ADDR_W-1:0] l1_rd_addr_i,
  input  logic                   l1_wr_req_i,
  input  logic [`GAT_ADDR_W-1:0] l1_wr_addr_i,
  input  logic [`GAT_WORD_W-1:0] l1_wr_data_i,
  input  logic                   l2_rd_req_i,
  input  logic [`GAT_ADDR_W-1:0] l2_rd_addr_i,
  input  logic                   l2_wr_req_i,
  input  logic [`GAT_ADDR_W-1:0] l2_wr_addr_i,
  input  logic [`GAT_WORD_W-1:0] l2_wr_data_i,
  output logic                   l1_rd_gnt_o,
  output logic                   l1_wr_gnt_o,
  output logic                   l2_rd_gnt_o,
  output logic                   l2_wr_gnt_o,
  output mem_word_u              rd_data_o,
  output logic [`GAT_WORD_W-1:0] host_dout_o
);

  logic [`GAT_WORD_W-1:0] mem [`GAT_MEM_DEPTH];
  logic                   eng_req;
  logic                   wr_en;
  logic [`GAT_ADDR_W-1:0] wr_addr;
  logic [`GAT_WORD_W-1:0] wr_data;
  logic [`GAT_ADDR_W-1:0] rd_addr;
  logic [`GAT_ADDR_W-1:0] host_rd_addr;

  // ========================================
  // Fixed priority grant
  // ========================================
  assign eng_req     = l1_rd_req_i | l1_wr_req_i | l2_rd_req_i | l2_wr_req_i;
  assign l1_wr_gnt_o = l1_wr_req_i & ~host_we_i;
  assign l1_rd_gnt_o = l1_rd_req_i & ~host_we_i & ~l1_wr_req_i;
  assign l2_wr_gnt_o = l2_wr_req_i & ~host_we_i & ~l1_wr_req_i & ~l1_rd_req_i;
  assign l2_rd_gnt_o = l2_rd_req_i & ~host_we_i & ~l1_wr_req_i & ~l1_rd_req_i & ~l2_wr_req_i;

  always_comb begin
    wr_en   = 1'b1;
    wr_addr = host_addr_i;
    wr_data = host_din_i;
    if (l1_wr_gnt_o) begin
      wr_addr = l1_wr_addr_i;
      wr_data = l1_wr_data_i;
    end else if (l2_wr_gnt_o) begin
      wr_addr = l2_wr_addr_i;
      wr_data = l2_wr_data_i;
    end else if (!host_we_i) begin
      wr_en = 1'b0;
    end
  end

  assign rd_addr      = l1_rd_gnt_o ? l1_rd_addr_i : l2_rd_addr_i;
  assign host_rd_addr = `GAT_ADDR_W'(`GAT_OUT_BASE) + `GAT_ADDR_W'(host_rd_idx_i);

  // ========================================
  // RAM
  // ========================================
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    if (l1_rd_gnt_o || l2_rd_gnt_o) begin
      rd_data_o <= mem[rd_addr];
    end
    // Host reads only fill idle cycles
    if (!eng_req) begin
      host_dout_o <= mem[host_rd_addr];
    end
  end

  a_layer_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !((l1_rd_req_i || l1_wr_req_i) && (l2_rd_req_i || l2_wr_req_i)));

  a_host_wr_idle: assert property (@(posedge clk) disable iff (!rst_n)
    host_we_i |-> !eng_req);

endmodule

//--- design/gat_mem_pkg.sv
// Shared feature memory word formats
`include "gat_settings.svh"

package gat_mem_pkg;

  // One nonzero of a sparse feature row
  typedef struct packed {
    logic                                              last;
    logic [`GAT_WORD_W-`GAT_COL_W-`GAT_DATA_W-2:0]     pad;
    logic [`GAT_COL_W-1:0]                             col;
    logic signed [`GAT_DATA_W-1:0]                     val;
  } sparse_entry_t;

  // Sparse rows for layer 1, dense values for layer 2 and host
  typedef union packed {
    sparse_entry_t                 sp;
    logic signed [`GAT_WORD_W-1:0] dense;
  } mem_word_u;

endpackage

//--- design/gat_settings.svh
// GAT core sizes and memory map
`ifndef GAT_SETTINGS_SVH
`define GAT_SETTINGS_SVH

// Graph and feature sizes
`define GAT_NUM_NODES   8
`define GAT_FEAT_IN     4
`define GAT_FEAT_HID    4
`define GAT_FEAT_OUT    3

// Data and word widths
`define GAT_DATA_W      8
`define GAT_WORD_W      20
`define GAT_COL_W       2

// Shared feature memory
`define GAT_MEM_DEPTH   128
`define GAT_ADDR_W      7
`define GAT_H_BASE      0
`define GAT_HID_BASE    64
`define GAT_OUT_BASE    96

// Weight memory, W1 first then W2
`define GAT_WGT_DEPTH   28
`define GAT_WGT_ADDR_W  5

// Layer 1 output scaling
`define GAT_L1_SHIFT    4

`endif

//--- design/gat_top.sv
// GAT accelerator core
`timescale 1ns/1ns
`include "gat_settings.svh"

module gat_top
  import gat_mem_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       h_we_i,
  input  logic [`GAT_ADDR_W-1:0]     h_addr_i,
  input  logic [`GAT_WORD_W-1:0]     h_din_i,
  input  logic                       h_load_done_i,
  input  logic                       wgt_we_i,
  input  logic [`GAT_WGT_ADDR_W-1:0] wgt_addr_i,
  input  logic [`GAT_DATA_W-1:0]     wgt_din_i,
  input  logic                       wgt_load_done_i,
  input  logic [4:0]                 feat_addr_i,
  output logic [`GAT_WORD_W-1:0]     feat_dout_o,
  output logic                       gat_ready_o
);

  localparam logic [1:0] L_IDLE  = 2'd0;
  localparam logic [1:0] L_CONV1 = 2'd1;
  localparam logic [1:0] L_CONV2 = 2'd2;
  localparam logic [1:0] L_DONE  = 2'd3;

  logic [1:0]                                               layer_q;
  logic                                                     conv1_start;
  logic                                                     conv2_start;
  logic                                                     conv1_done;
  logic                                                     conv2_done;
  logic                                                     wgt_rdy;
  logic [`GAT_FEAT_HID*`GAT_FEAT_IN*`GAT_DATA_W-1:0]        w1;
  logic [`GAT_FEAT_OUT*`GAT_FEAT_HID*`GAT_DATA_W-1:0]       w2;
  logic                                                     l1_rd_req;
  logic                                                     l1_rd_gnt;
  logic [`GAT_ADDR_W-1:0]                                   l1_rd_addr;
  logic                                                     l1_wr_req;
  logic                                                     l1_wr_gnt;
  logic [`GAT_ADDR_W-1:0]                                   l1_wr_addr;
  logic [`GAT_WORD_W-1:0]                                   l1_wr_data;
  logic                                                     l2_rd_req;
  logic                                                     l2_rd_gnt;
  logic [`GAT_ADDR_W-1:0]                                   l2_rd_addr;
  logic                                                     l2_wr_req;
  logic                                                     l2_wr_gnt;
  logic [`GAT_ADDR_W-1:0]                                   l2_wr_addr;
  logic [`GAT_WORD_W-1:0]                                   l2_wr_data;
  mem_word_u                                                rd_data;

  // ========================================
  // Layer sequencing
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      layer_q     <= L_IDLE;
      conv1_start <= 1'b0;
      conv2_start <= 1'b0;
      gat_ready_o <= 1'b0;
    end else begin
      conv1_start <= 1'b0;
      conv2_start <= 1'b0;
      case (layer_q)
        L_IDLE: begin
          if (wgt_rdy && h_load_done_i) begin
            conv1_start <= 1'b1;
            layer_q     <= L_CONV1;
          end
        end
        L_CONV1: begin
          if (conv1_done) begin
            conv2_start <= 1'b1;
            layer_q     <= L_CONV2;
          end
        end
        L_CONV2: begin
          if (conv2_done) begin
            gat_ready_o <= 1'b1;
            layer_q     <= L_DONE;
          end
        end
        default: layer_q <= L_DONE;
      endcase
    end
  end

  weight_loader u_weight_loader (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_we_i        (wgt_we_i),
    .wgt_addr_i      (wgt_addr_i),
    .wgt_din_i       (wgt_din_i),
    .wgt_load_done_i (wgt_load_done_i),
    .w1_o            (w1),
    .w2_o            (w2),
    .wgt_rdy_o       (wgt_rdy)
  );

  // Host writes only land before load done
  gat_mem_arbiter u_mem_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_we_i     (h_we_i & ~h_load_done_i),
    .host_addr_i   (h_addr_i),
    .host_din_i    (h_din_i),
    .host_rd_idx_i (feat_addr_i),
    .l1_rd_req_i   (l1_rd_req),
    .l1_rd_addr_i  (l1_rd_addr),
    .l1_wr_req_i   (l1_wr_req),
    .l1_wr_addr_i  (l1_wr_addr),
    .l1_wr_data_i  (l1_wr_data),
    .l2_rd_req_i   (l2_rd_req),
    .l2_rd_addr_i  (l2_rd_addr),
    .l2_wr_req_i   (l2_wr_req),
    .l2_wr_addr_i  (l2_wr_addr),
    .l2_wr_data_i  (l2_wr_data),
    .l1_rd_gnt_o   (l1_rd_gnt),
    .l1_wr_gnt_o   (l1_wr_gnt),
    .l2_rd_gnt_o   (l2_rd_gnt),
    .l2_wr_gnt_o   (l2_wr_gnt),
    .rd_data_o     (rd_data),
    .host_dout_o   (feat_dout_o)
  );

  sparse_conv_engine u_conv1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_i   (conv1_start),
    .w1_i      (w1),
    .rd_req_o  (l1_rd_req),
    .rd_addr_o (l1_rd_addr),
    .rd_gnt_i  (l1_rd_gnt),
    .rd_data_i (rd_data),
    .wr_req_o  (l1_wr_req),
    .wr_addr_o (l1_wr_addr),
    .wr_data_o (l1_wr_data),
    .wr_gnt_i  (l1_wr_gnt),
    .done_o    (conv1_done)
  );

  dense_conv_engine u_conv2 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_i   (conv2_start),
    .w2_i      (w2),
    .rd_req_o  (l2_rd_req),
    .rd_addr_o (l2_rd_addr),
    .rd_gnt_i  (l2_rd_gnt),
    .rd_data_i (rd_data),
    .wr_req_o  (l2_wr_req),
    .wr_addr_o (l2_wr_addr),
    .wr_data_o (l2_wr_data),
    .wr_gnt_i  (l2_wr_gnt),
    .done_o    (conv2_done)
  );

  // Each layer finishes only while it is the active one
  a_conv1_done: assert property (@(posedge clk) disable iff (!rst_n)
    conv1_done |-> (layer_q == L_CONV1));

  a_conv2_done: assert property (@(posedge clk) disable iff (!rst_n)
    conv2_done |-> (layer_q == L_CONV2));

endmodule

//--- design/sparse_conv_engine.sv
// Layer 1 sparse row times W1
`timescale 1ns/1ns
`include "gat_settings.svh"

module sparse_conv_engine
  import gat_mem_pkg::*;
(
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  logic                                               start_i,
  input  logic [`GAT_FEAT_HID*`GAT_FEAT_IN*`GAT_DATA_W-1:0]  w1_i,
  output logic                                               rd_req_o,
  output logic [`GAT_ADDR_W-1:0]                             rd_addr_o,
  input  logic                                               rd_gnt_i,
  input  mem_word_u                                          rd_data_i,
  output logic                                               wr_req_o,
  output logic [`GAT_ADDR_W-1:0]                             wr_addr_o,
  output logic [`GAT_WORD_W-1:0]                             wr_data_o,
  input  logic                                               wr_gnt_i,
  output logic                                               done_o
);

  localparam int ACC_W = 2 * `GAT_DATA_W + 2;
  localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'(2 ** (`GAT_DATA_W - 1) - 1);
  localparam logic signed [ACC_W-1:0] SAT_MIN = -SAT_MAX - 1'b1;
  localparam logic [1:0] S_IDLE    = 2'd0;
  localparam logic [1:0] S_RD_REQ  = 2'd1;
  localparam logic [1:0] S_RD_DATA = 2'd2;
  localparam logic [1:0] S_WRITE   = 2'd3;

  logic [1:0]                          state_q;
  logic [`GAT_ADDR_W-1:0]              rd_ptr_q;
  logic [$clog2(`GAT_NUM_NODES)-1:0]   node_q;
  logic [`GAT_COL_W-1:0]               wj_q;
  logic                                node_end;
  logic signed [ACC_W-1:0]             acc_q [`GAT_FEAT_HID];
  logic signed [2*`GAT_DATA_W-1:0]     prod [`GAT_FEAT_HID];
  logic signed [ACC_W-1:0]             shifted;

  assign rd_req_o  = (state_q == S_RD_REQ);
  assign rd_addr_o = `GAT_ADDR_W'(`GAT_H_BASE) + rd_ptr_q;
  assign wr_req_o  = (state_q == S_WRITE);
  assign wr_addr_o = `GAT_ADDR_W'(`GAT_HID_BASE + node_q * `GAT_FEAT_HID + wj_q);
  assign node_end  = wr_req_o && wr_gnt_i && (wj_q == `GAT_COL_W'(`GAT_FEAT_HID - 1));

  // Entry value times the W1 column it selects
  always_comb begin
    for (int j = 0; j < `GAT_FEAT_HID; j++) begin
      prod[j] = rd_data_i.sp.val * $signed(
        w1_i[(j * `GAT_FEAT_IN + int'(rd_data_i.sp.col)) * `GAT_DATA_W +: `GAT_DATA_W]);
    end
  end

  // Scale down and clamp to the data range
  always_comb begin
    shifted = acc_q[wj_q] >>> `GAT_L1_SHIFT;
    if (shifted > SAT_MAX) begin
      wr_data_o = `GAT_WORD_W'(SAT_MAX);
    end else if (shifted < SAT_MIN) begin
      wr_data_o = `GAT_WORD_W'(SAT_MIN);
    end else begin
      wr_data_o = `GAT_WORD_W'(shifted);
    end
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < `GAT_FEAT_HID; j++) begin
      if (start_i || node_end) begin
        acc_q[j] <= '0;
      end else if (state_q == S_RD_DATA) begin
        acc_q[j] <= acc_q[j] + ACC_W'(prod[j]);
      end
    end
  end

  // ========================================
  // Row walk
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= S_IDLE;
      rd_ptr_q <= '0;
      node_q   <= '0;
      wj_q     <= '0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            state_q  <= S_RD_REQ;
            rd_ptr_q <= '0;
            node_q   <= '0;
            wj_q     <= '0;
          end
        end
        S_RD_REQ: begin
          if (rd_gnt_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
            state_q  <= S_RD_DATA;
          end
        end
        S_RD_DATA: begin
          state_q <= rd_data_i.sp.last ? S_WRITE : S_RD_REQ;
        end
        default: begin
          if (wr_gnt_i) begin
            wj_q <= wj_q + 1'b1;
          end
          if (node_end) begin
            node_q <= node_q + 1'b1;
            if (node_q == $clog2(`GAT_NUM_NODES)'(`GAT_NUM_NODES - 1)) begin
              state_q <= S_IDLE;
              done_o  <= 1'b1;
            end else begin
              state_q <= S_RD_REQ;
            end
          end
        end
      endcase
    end
  end

  // Sparse entries carry a clean pad field
  a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == S_RD_DATA) |-> (rd_data_i.sp.pad == '0));

endmodule

//--- design/weight_loader.sv
// Weight RAM and W1/W2 register banks
`timescale 1ns/1ns
`include "gat_settings.svh"

module weight_loader (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 wgt_we_i,
  input  logic [`GAT_WGT_ADDR_W-1:0]                           wgt_addr_i,
  input  logic [`GAT_DATA_W-1:0]                               wgt_din_i,
  input  logic                                                 wgt_load_done_i,
  output logic [`GAT_FEAT_HID*`GAT_FEAT_IN*`GAT_DATA_W-1:0]    w1_o,
  output logic [`GAT_FEAT_OUT*`GAT_FEAT_HID*`GAT_DATA_W-1:0]   w2_o,
  output logic                                                 wgt_rdy_o
);

  localparam int W1_N = `GAT_FEAT_HID * `GAT_FEAT_IN;
  localparam logic [`GAT_WGT_ADDR_W-1:0] LAST = `GAT_WGT_ADDR_W'(`GAT_WGT_DEPTH - 1);

  logic [`GAT_DATA_W-1:0]                         wgt_mem [`GAT_WGT_DEPTH];
  logic [`GAT_DATA_W-1:0]                         rd_q;
  logic [`GAT_WGT_DEPTH-1:0][`GAT_DATA_W-1:0]     bank_q;
  logic                                           load_q;
  logic                                           started_q;
  logic                                           busy_q;
  logic [`GAT_WGT_ADDR_W-1:0]                     rd_cnt_q;
  logic                                           vld_q;
  logic [`GAT_WGT_ADDR_W-1:0]                     idx_q;

  always_ff @(posedge clk) begin
    if (wgt_we_i && !wgt_load_done_i) begin
      wgt_mem[wgt_addr_i] <= wgt_din_i;
    end
    rd_q <= wgt_mem[rd_cnt_q];
    if (vld_q) begin
      bank_q[idx_q] <= rd_q;
    end
  end

  // Unload sequence, one word per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_q    <= 1'b0;
      started_q <= 1'b0;
      busy_q    <= 1'b0;
      rd_cnt_q  <= '0;
      vld_q     <= 1'b0;
      idx_q     <= '0;
      wgt_rdy_o <= 1'b0;
    end else begin
      load_q <= wgt_load_done_i;
      vld_q  <= busy_q;
      idx_q  <= rd_cnt_q;
      if (load_q && !started_q) begin
        started_q <= 1'b1;
        busy_q    <= 1'b1;
        rd_cnt_q  <= '0;
      end else if (busy_q) begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
        if (rd_cnt_q == LAST) begin
          busy_q <= 1'b0;
        end
      end
      if (vld_q && idx_q == LAST) begin
        wgt_rdy_o <= 1'b1;
      end
    end
  end

  assign w1_o = bank_q[W1_N-1:0];
  assign w2_o = bank_q[`GAT_WGT_DEPTH-1:W1_N];

  a_no_late_write: assert property (@(posedge clk) disable iff (!rst_n)
    load_q |-> !wgt_we_i);

endmodule

//--- gat_accel.f
+incdir+design
+incdir+tb
design/gat_mem_pkg.sv
design/gat_mem_arbiter.sv
design/weight_loader.sv
design/sparse_conv_engine.sv
design/dense_conv_engine.sv
design/gat_top.sv
tb/gat_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the GAT core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module gat_tb \
  -f gat_accel.f -o gat_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/gat_sim > sim.log 2>&1 || echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

//--- tb/gat_ref_model.svh
// GAT data set generator and reference model
`ifndef GAT_REF_MODEL_SVH
`define GAT_REF_MODEL_SVH

logic [31:0]            rng_state;
logic [`GAT_WORD_W-1:0] sp_word [64];
int                     sp_len;
logic [`GAT_DATA_W-1:0] wgt [`GAT_WGT_DEPTH];
int                     hid [`GAT_NUM_NODES][`GAT_FEAT_HID];
int                     exp_out [`GAT_NUM_NODES*`GAT_FEAT_OUT];

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] next_rand();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

// Mode 0 random, 1 saturating, 2 one entry per row with negative weights
function automatic void build_data_set(input int mode);
  logic [3:0]        mask;
  logic signed [7:0] v;
  int                idx;
  idx = 0;
  for (int w = 0; w < `GAT_WGT_DEPTH; w++) begin
    if (mode == 1 && w < 16) begin
      wgt[w] = 8'(100 + next_rand() % 28);
    end else if (mode == 2) begin
      wgt[w] = 8'(-(1 + int'(next_rand() % 128)));
    end else begin
      wgt[w] = 8'(next_rand());
    end
  end
  for (int n = 0; n < `GAT_NUM_NODES; n++) begin
    if (mode == 2) begin
      mask = 4'b0001 << (next_rand() % 4);
    end else begin
      mask = 4'(next_rand() % 15 + 1);
    end
    for (int c = 0; c < `GAT_FEAT_IN; c++) begin
      if (mask[c]) begin
        if (mode == 1) begin
          // Odd nodes drive the lower clamp
          v = (n % 2 == 1) ? 8'(-100 - int'(next_rand() % 29)) : 8'(100 + next_rand() % 28);
        end else if (mode == 2 && n % 3 == 0) begin
          v = 8'sd0;
        end else begin
          v = 8'(next_rand());
        end
        sp_word[idx] = {1'b0, 9'd0, 2'(c), v};
        idx++;
      end
    end
    sp_word[idx-1][`GAT_WORD_W-1] = 1'b1;
  end
  sp_len = idx;
endfunction

function automatic void compute_model();
  int                acc [`GAT_FEAT_HID];
  int                s;
  int                n;
  int                col;
  logic signed [7:0] val;
  n = 0;
  for (int j = 0; j < `GAT_FEAT_HID; j++) begin
    acc[j] = 0;
  end
  for (int e = 0; e < sp_len; e++) begin
    val = sp_word[e][7:0];
    col = int'(sp_word[e][9:8]);
    for (int j = 0; j < `GAT_FEAT_HID; j++) begin
      acc[j] += int'(val) * int'($signed(wgt[j*4+col]));
    end
    if (sp_word[e][`GAT_WORD_W-1]) begin
      for (int j = 0; j < `GAT_FEAT_HID; j++) begin
        s = acc[j] >>> `GAT_L1_SHIFT;
        hid[n][j] = (s > 127) ? 127 : ((s < -128) ? -128 : s);
        acc[j] = 0;
      end
      n++;
    end
  end
  // Layer 2 keeps the full sum
  for (int m = 0; m < `GAT_NUM_NODES; m++) begin
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      s = 0;
      for (int j = 0; j < `GAT_FEAT_HID; j++) begin
        s += hid[m][j] * int'($signed(wgt[16+k*4+j]));
      end
      exp_out[m*3+k] = s;
    end
  end
endfunction

`endif

//--- tb/gat_tb.sv
// GAT core testbench
`timescale 1ns/1ns
`include "gat_settings.svh"

module gat_tb;

  localparam int NUM_TESTS   = 5;
  localparam int TEST_CYCLES = 3000;
  localparam int WATCHDOG_NS = NUM_TESTS * TEST_CYCLES * 20;
  localparam int NUM_FEAT    = `GAT_NUM_NODES * `GAT_FEAT_OUT;

  logic                       clk;
  logic                       rst_n;
  logic                       h_we_i;
  logic [`GAT_ADDR_W-1:0]     h_addr_i;
  logic [`GAT_WORD_W-1:0]     h_din_i;
  logic                       h_load_done_i;
  logic                       wgt_we_i;
  logic [`GAT_WGT_ADDR_W-1:0] wgt_addr_i;
  logic [`GAT_DATA_W-1:0]     wgt_din_i;
  logic                       wgt_load_done_i;
  logic [4:0]                 feat_addr_i;
  logic [`GAT_WORD_W-1:0]     feat_dout_o;
  logic                       gat_ready_o;

  int tests_run;
  int tests_passed;
  int tests_failed;
  int old_out [NUM_FEAT];

  `include "gat_ref_model.svh"

  gat_top dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .h_we_i          (h_we_i),
    .h_addr_i        (h_addr_i),
    .h_din_i         (h_din_i),
    .h_load_done_i   (h_load_done_i),
    .wgt_we_i        (wgt_we_i),
    .wgt_addr_i      (wgt_addr_i),
    .wgt_din_i       (wgt_din_i),
    .wgt_load_done_i (wgt_load_done_i),
    .feat_addr_i     (feat_addr_i),
    .feat_dout_o     (feat_dout_o),
    .gat_ready_o     (gat_ready_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

  // ========================================
  // Host side tasks
  // ========================================
  task automatic apply_reset();
    @(negedge clk);
    rst_n           = 1'b0;
    h_we_i          = 1'b0;
    wgt_we_i        = 1'b0;
    h_load_done_i   = 1'b0;
    wgt_load_done_i = 1'b0;
    feat_addr_i     = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic load_inputs(input bit release_h);
    for (int w = 0; w < `GAT_WGT_DEPTH; w++) begin
      @(negedge clk);
      wgt_we_i   = 1'b1;
      wgt_addr_i = `GAT_WGT_ADDR_W'(w);
      wgt_din_i  = wgt[w];
    end
    for (int a = 0; a < sp_len; a++) begin
      @(negedge clk);
      wgt_we_i = 1'b0;
      h_we_i   = 1'b1;
      h_addr_i = `GAT_ADDR_W'(a);
      h_din_i  = sp_word[a];
    end
    @(negedge clk);
    h_we_i          = 1'b0;
    wgt_we_i        = 1'b0;
    wgt_load_done_i = 1'b1;
    h_load_done_i   = release_h;
  endtask

  task automatic wait_ready(output bit ok);
    int cycles;
    cycles = 0;
    while (!gat_ready_o && cycles < TEST_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    ok = gat_ready_o;
  endtask

  // Address goes out on one falling edge, data is sampled on the next
  task automatic check_outputs(input bit check_stale, inout int errs);
    logic [`GAT_WORD_W-1:0] want;
    logic [`GAT_WORD_W-1:0] old;
    for (int i = 0; i < NUM_FEAT; i++) begin
      @(negedge clk);
      feat_addr_i = 5'(i);
      @(negedge clk);
      want = `GAT_WORD_W'(exp_out[i]);
      old  = `GAT_WORD_W'(old_out[i]);
      if (feat_dout_o !== want) begin
        $display("MISMATCH t=%0t feat_dout_o[%0d] got %h expected %h",
                 $time, i, feat_dout_o, want);
        errs++;
        if (check_stale && feat_dout_o === old) begin
          $display("Word %0d still holds the result of the previous data set", i);
        end
      end
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs);
    tests_run++;
    if (errs == 0) begin
      tests_passed++;
      $display("Test %0d %s: PASS", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL with %0d errors", num, name, errs);
    end
  endtask

  // ========================================
  // Tests
  // ========================================
  task automatic check_ready_hold();
    int errs;
    errs = 0;
    apply_reset();
    if (gat_ready_o !== 1'b0) begin
      $display("MISMATCH t=%0t gat_ready_o got %b expected 0", $time, gat_ready_o);
      errs++;
    end
    build_data_set(0);
    load_inputs(1'b0);
    repeat (50) begin
      @(negedge clk);
      if (gat_ready_o !== 1'b0) begin
        $display("MISMATCH t=%0t gat_ready_o got %b expected 0", $time, gat_ready_o);
        errs++;
      end
    end
    report_test(1, "ready held while sparse load pending", errs);
  endtask

  task automatic run_graph_test(input int num, input string name, input int mode,
                                input bit check_stale);
    int errs;
    bit ok;
    errs = 0;
    old_out = exp_out;
    build_data_set(mode);
    compute_model();
    apply_reset();
    load_inputs(1'b1);
    wait_ready(ok);
    if (!ok) begin
      $display("gat_ready_o did not rise within %0d cycles at t=%0t", TEST_CYCLES, $time);
      errs++;
    end else begin
      check_outputs(check_stale, errs);
    end
    report_test(num, name, errs);
  endtask

  initial begin
    rst_n           = 1'b0;
    h_we_i          = 1'b0;
    h_addr_i        = '0;
    h_din_i         = '0;
    h_load_done_i   = 1'b0;
    wgt_we_i        = 1'b0;
    wgt_addr_i      = '0;
    wgt_din_i       = '0;
    wgt_load_done_i = 1'b0;
    feat_addr_i     = '0;
    tests_run       = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    rng_state       = 32'h612c_b39c;
    for (int i = 0; i < NUM_FEAT; i++) begin
      exp_out[i] = 0;
    end

    check_ready_hold();
    run_graph_test(2, "random graph", 0, 1'b0);
    run_graph_test(3, "hidden saturation", 1, 1'b0);
    run_graph_test(4, "single entry rows", 2, 1'b0);
    run_graph_test(5, "reload after reset", 0, 1'b1);

    $display("Tests run %0d, passed %0d, failed %0d", tests_run, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
